//--- source/fixnum_pkg.sv
// Fixed-point word format for the output layer datapath, imported by every arithmetic block
package fixnum_pkg;

	// Word layout is sign, integer part, fraction part
	localparam int WIDTH     = 16;       // Full word width
	localparam int INT_BITS  = 5;        // Integer magnitude bits
	localparam int FRAC_BITS = 10;       // Fraction bits, 1 LSB = 2^-10

	// 1.0 in the fixed-point format
	localparam logic signed [WIDTH-1:0] ONE_FIX = WIDTH'(1) << FRAC_BITS;

	// Field view of a word, MSB first
	typedef struct packed {
		logic                 sign;      // Two's complement sign
		logic [INT_BITS-1:0]  int_part;  // Integer bits
		logic [FRAC_BITS-1:0] frac_part; // Fraction bits, MSB weighs 0.5
	} fix_fields_t;

	// One word seen two ways
	// raw for add/sub/mul, fields for thresholding
	typedef union packed {
		logic signed [WIDTH-1:0] raw;    // Arithmetic view
		fix_fields_t             fields; // Bit field view
	} fix_word_u;

endpackage

//--- source/layer_pkg.sv
// Output layer geometry defaults, cost codes and junction cycle length used across the layer
package layer_pkg;

	// Cost function select
	localparam bit COST_QUAD = 1'b0; // Quadratic, delta = (a - y) * sp
	localparam bit COST_XENT = 1'b1; // Cross-entropy, delta = a - y

	// Default geometry of the top level
	localparam int P_DEFAULT = 4;    // Neurons in the output layer
	localparam int Z_DEFAULT = 1;    // Neurons handled per clock
	localparam int L_DEFAULT = 3;    // Layers in the whole network

	// Idle slots at the end of every junction cycle
	// These give the memory read pipeline room before the banks swap
	localparam int CPC_EXTRA = 2;

	// Clocks per junction cycle for a layer of p neurons at z per clock
	function automatic int cpc_of(input int p, input int z);
		return p / z + CPC_EXTRA;
	endfunction

endpackage

//--- source/ideal_output_delay.sv
// Delay line that holds the ideal output bits while activations cross the earlier layers
`timescale 1ns/1ps

module ideal_output_delay #(
	parameter int Z = layer_pkg::Z_DEFAULT, // Lanes per clock
	parameter int P = layer_pkg::P_DEFAULT, // Neurons in the layer
	parameter int L = layer_pkg::L_DEFAULT  // Layers in the network, at least 2
)(
	input  logic         clk,
	input  logic         arst_n_i,
	input  logic [Z-1:0] y_i,         // Ideal bits entering with the input layer
	output logic [Z-1:0] y_delayed_o  // Same bits, lined up with the last layer
);

	import layer_pkg::*;

	localparam int CPC   = cpc_of(P, Z);  // Clocks per junction cycle
	localparam int DEPTH = CPC * (L - 1); // One junction cycle per earlier layer

	logic [Z-1:0] stage_q [DEPTH]; // stage_q[0] is the newest entry

	// Plain shift by one stage every clock
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0; // Nothing valid in flight after reset
			end
		end else begin
			stage_q[0] <= y_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// Bit sampled DEPTH clocks ago
	assign y_delayed_o = stage_q[DEPTH-1];

endmodule

//--- source/neuron_cost_unit.sv
// Per-lane cost term, delta by cost type and one-bit output decision for the output layer
`timescale 1ns/1ps

module neuron_cost_unit #(
	parameter int Z         = layer_pkg::Z_DEFAULT, // Lanes per clock
	parameter bit COST_TYPE = layer_pkg::COST_XENT  // Cost function select
)(
	input  fixnum_pkg::fix_word_u [Z-1:0] act_i,   // Computed activations
	input  fixnum_pkg::fix_word_u [Z-1:0] sp_i,    // Sigmoid prime, quadratic cost only
	input  logic                  [Z-1:0] y_i,     // Delayed ideal outputs
	output fixnum_pkg::fix_word_u [Z-1:0] delta_o, // Output layer deltas
	output logic                  [Z-1:0] a_out_o  // Thresholded network outputs
);

	import fixnum_pkg::*;
	import layer_pkg::*;

	for (genvar g = 0; g < Z; g++) begin : g_lane
		fix_word_u cost_term; // a - y for this lane

		// Ideal bit selects 1.0 or 0.0 as the target
		assign cost_term = act_i[g].raw - (y_i[g] ? ONE_FIX : '0);

		if (COST_TYPE == COST_QUAD) begin : g_quad
			logic signed [2*WIDTH-1:0] prod;     // Full product, 2*FRAC_BITS fraction bits
			logic signed [2*WIDTH-1:0] prod_shr; // Back to FRAC_BITS fraction bits

			assign prod     = $signed(cost_term.raw) * $signed(sp_i[g].raw);
			assign prod_shr = prod >>> FRAC_BITS;      // Truncates toward minus infinity
			assign delta_o[g] = prod_shr[WIDTH-1:0]; // Low word, no saturation
		end else begin : g_xent
			// Sigmoid prime cancels out of the cross-entropy gradient
			assign delta_o[g] = cost_term;
		end

		// Output is 1 for a non-negative activation at or above 0.5
		// Any integer bit set, or the half bit of the fraction
		assign a_out_o[g] = !act_i[g].fields.sign &&
			((|act_i[g].fields.int_part) || act_i[g].fields.frac_part[FRAC_BITS-1]);
	end

endmodule

//--- source/delta_bank_ctrl.sv
// Junction cycle counter and bank pointer driving the write enable and addresses of the delta memory
`timescale 1ns/1ps

module delta_bank_ctrl #(
	parameter int P = layer_pkg::P_DEFAULT, // Neurons in the layer, multiple of Z
	parameter int Z = layer_pkg::Z_DEFAULT  // Lanes per clock
)(
	input  logic                     clk,
	input  logic                     arst_n_i,
	output logic                     wr_bank_o, // Bank being written, reads use the other
	output logic                     wr_en_o,   // Delta write strobe
	output logic [$clog2(P/Z)-1:0]   wr_addr_o, // Write row
	output logic [$clog2(P/Z)-1:0]   rd_addr_o  // Read row in the other bank
);

	import layer_pkg::*;

	localparam int CPC   = cpc_of(P, Z);  // Clocks per junction cycle
	localparam int DEPTH = P / Z;         // Busy slots per junction cycle
	localparam int CW    = $clog2(CPC);   // Cycle index width
	localparam int AW    = $clog2(DEPTH); // Row address width

	logic [CW-1:0] cycle_q;   // Position in the junction cycle
	logic          wr_bank_q; // Ping-pong pointer
	logic          wrap;      // Last slot of the junction cycle

	assign wrap = (cycle_q == CW'(CPC - 1));

	// Index starts at 0 on the first clock out of reset
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cycle_q   <= '0;
			wr_bank_q <= 1'b0;
		end else begin
			cycle_q   <= wrap ? '0 : cycle_q + 1'b1;
			wr_bank_q <= wr_bank_q ^ wrap; // Swap banks with the new junction cycle
		end
	end

	assign wr_bank_o = wr_bank_q;
	// Idle slots and reset write nothing
	assign wr_en_o   = arst_n_i && (int'(cycle_q) < DEPTH);
	assign wr_addr_o = cycle_q[AW-1:0];         // One row per busy slot
	assign rd_addr_o = cycle_q[AW-1:0];         // Read walks in step with the write

	// Counter never leaves the junction cycle
	a_cycle_range : assert property (@(posedge clk) disable iff (!arst_n_i)
		int'(cycle_q) < CPC)
		else $error("junction cycle index out of range");

	// Write row stays inside the bank and equals the full slot index
	a_wr_in_busy : assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_en_o |-> ((int'(wr_addr_o) < DEPTH) && (CW'(wr_addr_o) == cycle_q)))
		else $error("delta write outside the busy slots");

	// Bank swap only lands on slot 0
	a_bank_swap : assert property (@(posedge clk) disable iff (!arst_n_i)
		$changed(wr_bank_q) |-> (cycle_q == '0))
		else $error("bank pointer moved away from a wrap");

endmodule

//--- source/delta_ping_pong_mem.sv
// Two-bank delta store, one bank filled by the cost unit while the other is read back to the previous layer
`timescale 1ns/1ps

module delta_ping_pong_mem #(
	parameter int P = layer_pkg::P_DEFAULT, // Neurons in the layer, multiple of Z
	parameter int Z = layer_pkg::Z_DEFAULT  // Lanes per row
)(
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  logic                          wr_bank_i, // Bank to write, read is the other one
	input  logic                          wr_en_i,
	input  logic [$clog2(P/Z)-1:0]        wr_addr_i,
	input  logic [$clog2(P/Z)-1:0]        rd_addr_i,
	input  fixnum_pkg::fix_word_u [Z-1:0] wr_data_i, // Z deltas per row
	output fixnum_pkg::fix_word_u [Z-1:0] rd_data_o  // Registered read, one clock late
);

	import fixnum_pkg::*;

	localparam int DEPTH = P / Z; // Rows per bank

	fix_word_u [Z-1:0] bank_mem [2][DEPTH]; // [bank][row]
	logic      [1:0]   bank_vld_q;          // Bank holds at least one written row
	fix_word_u [Z-1:0] rd_q;
	logic              rd_bank;
	logic              rd_ok;

	assign rd_bank = ~wr_bank_i;
	// Never-written bank or row past the end reads as 0
	assign rd_ok   = bank_vld_q[rd_bank] && (int'(rd_addr_i) < DEPTH);

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			bank_mem[wr_bank_i][wr_addr_i] <= wr_data_i;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bank_vld_q <= '0;
			rd_q       <= '0;
		end else begin
			if (wr_en_i) begin
				bank_vld_q[wr_bank_i] <= 1'b1;
			end
			rd_q <= rd_ok ? bank_mem[rd_bank][rd_addr_i] : '0;
		end
	end

	assign rd_data_o = rd_q;

	// Read never lands on the bank written this clock or the one before
	// Relies on the idle slot the controller puts before every bank swap
	a_bank_split : assert property (@(posedge clk) disable iff (!arst_n_i)
		$past(wr_en_i) |-> (rd_bank != $past(wr_bank_i)))
		else $error("delta read hit the bank being written");

endmodule

//--- source/output_layer.sv
// Output layer top, ties the ideal-bit delay, cost unit, bank controller and delta memory together
`timescale 1ns/1ps

module output_layer #(
	parameter int P         = layer_pkg::P_DEFAULT, // Neurons, multiple of Z
	parameter int Z         = layer_pkg::Z_DEFAULT, // Neurons per clock
	parameter int L         = layer_pkg::L_DEFAULT, // Layers in the network
	parameter bit COST_TYPE = layer_pkg::COST_XENT  // Cost function select
)(
	input  logic                          clk,
	input  logic                          arst_n_i,
	input  fixnum_pkg::fix_word_u [Z-1:0] act_i,       // Activations from the last layer
	input  fixnum_pkg::fix_word_u [Z-1:0] sp_i,        // Matching sigmoid primes
	input  logic                  [Z-1:0] y_i,         // Ideal outputs at network entry
	output fixnum_pkg::fix_word_u [Z-1:0] delta_o,     // Deltas back to the previous layer
	output logic                  [Z-1:0] y_delayed_o, // Ideal outputs lined up with act_i
	output logic                  [Z-1:0] a_out_o      // One-bit network outputs
);

	import fixnum_pkg::*;

	localparam int AW = $clog2(P / Z); // Delta row address width

	fix_word_u [Z-1:0] delta_lanes; // Fresh deltas into the memory
	logic              wr_bank;
	logic              wr_en;
	logic [AW-1:0]     wr_addr;
	logic [AW-1:0]     rd_addr;

	ideal_output_delay #(.Z(Z), .P(P), .L(L)) u_y_delay (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.y_i         (y_i),
		.y_delayed_o (y_delayed_o)
	);

	neuron_cost_unit #(.Z(Z), .COST_TYPE(COST_TYPE)) u_cost (
		.act_i   (act_i),
		.sp_i    (sp_i),
		.y_i     (y_delayed_o), // Target bits for this clock
		.delta_o (delta_lanes),
		.a_out_o (a_out_o)
	);

	delta_bank_ctrl #(.P(P), .Z(Z)) u_ctrl (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.wr_bank_o (wr_bank),
		.wr_en_o   (wr_en),
		.wr_addr_o (wr_addr),
		.rd_addr_o (rd_addr)
	);

	delta_ping_pong_mem #(.P(P), .Z(Z)) u_delta_mem (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.wr_bank_i (wr_bank),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.rd_addr_i (rd_addr),
		.wr_data_i (delta_lanes),
		.rd_data_o (delta_o) // Previous junction cycle's deltas
	);

endmodule

//--- tests/tb_output_layer.sv
// Self-checking testbench for output_layer, random stream from a fixed seed checked against a model
`timescale 1ns/1ps

module tb_output_layer #(
	parameter int P         = layer_pkg::P_DEFAULT, // Neurons, multiple of Z
	parameter int Z         = layer_pkg::Z_DEFAULT, // Neurons per clock
	parameter int L         = layer_pkg::L_DEFAULT, // Layers in the network, at least 2
	parameter bit COST_TYPE = layer_pkg::COST_XENT  // Cost function under test
);

	import fixnum_pkg::*;
	import layer_pkg::*;

	localparam int PERIOD       = 10;              // Clock period in ns
	localparam int RESET_CYCLES = 4;
	localparam int NUM_FRAMES   = 24;              // Junction cycles to run
	localparam int MARGIN       = 20;              // Spare clocks for the watchdog
	localparam int DEPTH        = P / Z;           // Busy slots per junction cycle
	localparam int CPC          = DEPTH + CPC_EXTRA;
	localparam int Y_DELAY      = CPC * (L - 1);   // Ideal bit latency in clocks
	localparam int ONE          = int'(ONE_FIX);   // 1.0 as an integer
	localparam int WATCHDOG_NS  = (NUM_FRAMES * CPC + RESET_CYCLES + MARGIN) * PERIOD;

	logic              clk = 1'b0;
	logic              arst_n_i;
	fix_word_u [Z-1:0] act;
	fix_word_u [Z-1:0] sp;
	logic      [Z-1:0] y;
	fix_word_u [Z-1:0] delta;
	logic      [Z-1:0] y_delayed;
	logic      [Z-1:0] a_out;

	integer            seed = 32'h1e94_4dcf;
	logic [Z-1:0]      y_hist [$];                 // Ideal bits still inside the delay line
	logic [WIDTH-1:0]  exp_bank [2][DEPTH][Z];     // Model of both delta banks

	output_layer #(.P(P), .Z(Z), .L(L), .COST_TYPE(COST_TYPE)) dut0 (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.act_i       (act),
		.sp_i        (sp),
		.y_i         (y),
		.delta_o     (delta),
		.y_delayed_o (y_delayed),
		.a_out_o     (a_out)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Uniform integer in 0..hi
	function automatic int rand_upto(input int hi);
		return int'($unsigned($random(seed)) % (hi + 1));
	endfunction

	// Activation in 0..1.0 with the threshold corners mixed in
	function automatic int pick_activation();
		int sel;
		sel = rand_upto(9);
		case (sel)
			0:       return 0;
			1:       return ONE / 2;     // Exactly 0.5
			2:       return ONE / 2 - 1; // Just below 0.5
			3:       return ONE;
			default: return rand_upto(ONE);
		endcase
	endfunction

	// Delta from the cost rule, quadratic keeps the floor of the product
	function automatic logic [WIDTH-1:0] expected_delta(input int a, input int s, input bit yb);
		int     cost;
		longint prod;
		cost = a - (yb ? ONE : 0);
		if (COST_TYPE == COST_QUAD) begin
			prod = longint'(cost) * longint'(s);
			prod = prod >>> FRAC_BITS;        // Arithmetic shift rounds down
			return WIDTH'(prod);
		end
		return WIDTH'(cost);
	endfunction

	// Non-negative and at least one half
	function automatic bit expected_a_out(input int a);
		return (a >= 0) && (a >= ONE / 2);
	endfunction

	// Single comparison point, first mismatch ends the run
	task automatic compare_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("Fail %s expected %0h actual %0h", name, exp_v, act_v);
			$display("STATUS: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// One clock: drive on the falling edge, then check everything visible in it
	task automatic drive_and_check_clock(input int n);
		int           k;
		int           j;
		int           a_v [Z];
		int           s_v [Z];
		logic [Z-1:0] y_v;
		logic [Z-1:0] exp_y;
		k = n % CPC; // Slot in the junction cycle
		j = n / CPC; // Junction cycle since reset
		for (int g = 0; g < Z; g++) begin
			a_v[g]     = pick_activation();
			s_v[g]     = rand_upto(ONE / 4);
			act[g].raw = WIDTH'(a_v[g]);
			sp[g].raw  = WIDTH'(s_v[g]);
		end
		y_v = Z'($random(seed));
		y   = y_v;

		// Front of a full history is the bit from Y_DELAY clocks ago
		exp_y = (y_hist.size() == Y_DELAY) ? y_hist[0] : '0;
		y_hist.push_back(y_v);
		if (y_hist.size() > Y_DELAY) begin
			void'(y_hist.pop_front());
		end

		#1; // Let the combinational path settle
		compare_value($sformatf("y_delayed clock %0d", n), 32'(exp_y), 32'(y_delayed));

		for (int g = 0; g < Z; g++) begin
			compare_value($sformatf("a_out lane %0d clock %0d act %0d", g, n, a_v[g]),
				32'(expected_a_out(a_v[g])), 32'(a_out[g]));

			if (j == 0) begin
				// Nothing written before this junction cycle
				compare_value($sformatf("delta first cycle lane %0d clock %0d", g, n),
					32'(0), 32'($unsigned(delta[g].raw)));
			end else if (k >= 1 && k - 1 < DEPTH) begin
				// Row k-1 from the bank filled in the previous junction cycle
				compare_value($sformatf("delta row %0d lane %0d frame %0d", k - 1, g, j),
					32'(exp_bank[(j + 1) % 2][k - 1][g]), 32'($unsigned(delta[g].raw)));
			end

			if (k < DEPTH) begin
				exp_bank[j % 2][k][g] = expected_delta(a_v[g], s_v[g], exp_y[g]);
			end
		end
	endtask

	initial begin
		arst_n_i = 1'b0;
		act      = '0;
		sp       = '0;
		y        = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n_i = 1'b1; // Clock 0 of the first junction cycle starts here

		for (int n = 0; n < NUM_FRAMES * CPC; n++) begin
			if (n > 0) begin
				@(negedge clk);
			end
			drive_and_check_clock(n);
		end

		$display("STATUS: PASS");
		$finish;
	end

	// Hard stop if the stream loop never completes
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the test did not finish within %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- filelist.f
source/fixnum_pkg.sv
source/layer_pkg.sv
source/ideal_output_delay.sv
source/neuron_cost_unit.sv
source/delta_bank_ctrl.sv
source/delta_ping_pong_mem.sv
source/output_layer.sv
tests/tb_output_layer.sv

//--- Makefile
# Verilator build, run and lint for the output layer

VERILATOR ?= verilator
TOP       ?= tb_output_layer
DUT_TOP   ?= output_layer
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

# Layer geometry and cost type, passed as top parameters
P         ?= 4
Z         ?= 1
L         ?= 3
COST_TYPE ?= 0

VFLAGS    ?= --timing --assert
PARAMS     = -GP=$(P) -GZ=$(Z) -GL=$(L) -GCOST_TYPE=$(COST_TYPE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) $(PARAMS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(PARAMS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
